// ==== source/dot_pkg.sv ====
// widths fixed at 16 lanes of 8-bit operands; every result is exact in 22 bits
`default_nettype none

package dot_pkg;

  // lane and operand geometry
  localparam int lane_count    = 16;
  localparam int operand_width = 8;
  localparam int brick_width   = 2;
  localparam int plane_count   = operand_width / brick_width;
  localparam int blade_count   = plane_count * plane_count;

  // one extra bit per brick for the sign of a top brick
  localparam int ext_width = brick_width + 1;

  // signed 3x3 product ranges from -6 to 9
  localparam int prod_width = 2 * ext_width;

  // sixteen products per blade need four more bits
  localparam int blade_sum_width = prod_width + 4;

  // full signed dot product
  localparam int dot_width = 22;

  // which operands are signed
  typedef enum logic [1:0] {
    mode_uu = 2'b00,
    mode_us = 2'b01,
    mode_su = 2'b10,
    mode_ss = 2'b11
  } dot_mode_e;

  // sixteen operand pairs taken in one cycle
  typedef struct packed {
    logic [lane_count-1:0][operand_width-1:0] a;
    logic [lane_count-1:0][operand_width-1:0] b;
  } lane_ops_t;

  // one brick after extension
  typedef logic [ext_width-1:0] ext_brick_t;

  // the same brick position across all lanes
  typedef ext_brick_t [lane_count-1:0] brick_plane_t;

  // plane 0 holds bits 1:0, plane 3 holds bits 7:6
  typedef struct packed {
    brick_plane_t [plane_count-1:0] a_planes;
    brick_plane_t [plane_count-1:0] b_planes;
  } brick_planes_t;

  // registered output of one blade
  typedef logic signed [blade_sum_width-1:0] blade_sum_t;

  // index is a plane times four plus b plane
  typedef blade_sum_t [blade_count-1:0] blade_sums_t;

endpackage

`default_nettype wire

// ==== source/brick_decode.sv ====
// combinational; only the top brick of an operand marked signed by the mode is sign-extended
`default_nettype none

module brick_decode (
  input  wire dot_pkg::lane_ops_t     ops,
  input  wire dot_pkg::dot_mode_e     mode,
  output dot_pkg::brick_planes_t      planes
);

  import dot_pkg::*;

  logic a_signed;
  logic b_signed;

  // copy the brick msb up only when asked
  function automatic ext_brick_t ext_brick(
    input logic [brick_width-1:0] brick,
    input logic                   sign_ext
  );
    return {sign_ext & brick[brick_width-1], brick};
  endfunction

  // mode bit 1 marks a, bit 0 marks b
  assign a_signed = (mode == mode_su) || (mode == mode_ss);
  assign b_signed = (mode == mode_us) || (mode == mode_ss);

  always_comb begin
    planes = '0;
    for (int p = 0; p < plane_count; p++) begin
      for (int l = 0; l < lane_count; l++) begin
        planes.a_planes[p][l] = ext_brick(
          ops.a[l][p*brick_width +: brick_width],
          a_signed && (p == plane_count - 1)
        );
        planes.b_planes[p][l] = ext_brick(
          ops.b[l][p*brick_width +: brick_width],
          b_signed && (p == plane_count - 1)
        );
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/brick_blade.sv ====
// one brick plane pair; sum range is -96 to 144 and is registered with one cycle of latency
`default_nettype none

module brick_blade (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire dot_pkg::brick_plane_t               a_plane,
  input  wire dot_pkg::brick_plane_t               b_plane,
  output logic signed [dot_pkg::blade_sum_width-1:0] blade_sum
);

  import dot_pkg::*;

  // per-lane brick products
  logic signed [prod_width-1:0] prod [lane_count];

  // adder tree grows one bit per level
  logic signed [prod_width:0]   sum_l1 [lane_count/2];
  logic signed [prod_width+1:0] sum_l2 [lane_count/4];
  logic signed [prod_width+2:0] sum_l3 [lane_count/8];
  logic signed [blade_sum_width-1:0] sum_all;

  for (genvar k = 0; k < lane_count; k++) begin : g_lane
    logic signed [ext_width-1:0] a_brick;
    logic signed [ext_width-1:0] b_brick;

    assign a_brick = a_plane[k];
    assign b_brick = b_plane[k];

    // zero-extended bricks stay positive, top signed bricks may go negative
    assign prod[k] = a_brick * b_brick;
  end

  always_comb begin
    for (int n = 0; n < lane_count/2; n++) begin
      sum_l1[n] = prod[2*n] + prod[2*n+1];
    end
    for (int n = 0; n < lane_count/4; n++) begin
      sum_l2[n] = sum_l1[2*n] + sum_l1[2*n+1];
    end
    for (int n = 0; n < lane_count/8; n++) begin
      sum_l3[n] = sum_l2[2*n] + sum_l2[2*n+1];
    end
    sum_all = sum_l3[0] + sum_l3[1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      blade_sum <= '0;
    end else begin
      blade_sum <= sum_all;
    end
  end

endmodule

`default_nettype wire

// ==== source/blade_array.sv ====
// all sixteen plane pairs in regular order; blade index is a plane times four plus b plane
`default_nettype none

module blade_array (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire dot_pkg::brick_planes_t planes,
  output dot_pkg::blade_sums_t        sums
);

  import dot_pkg::*;

  blade_sum_t blade_q [blade_count];

  for (genvar i = 0; i < plane_count; i++) begin : g_a_plane
    for (genvar j = 0; j < plane_count; j++) begin : g_b_plane
      brick_blade u_blade (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_plane   (planes.a_planes[i]),
        .b_plane   (planes.b_planes[j]),
        .blade_sum (blade_q[i*plane_count + j])
      );
    end
  end

  // gather into the packed bundle for the result stage
  always_comb begin
    for (int k = 0; k < blade_count; k++) begin
      sums[k] = blade_q[k];
    end
  end

endmodule

`default_nettype wire

// ==== source/shift_add.sv ====
// blade weights follow from the index alone; output is 22-bit two's complement one cycle late
`default_nettype none

module shift_add (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire dot_pkg::blade_sums_t        sums,
  output logic [dot_pkg::dot_width-1:0]    dot
);

  import dot_pkg::*;

  // each blade sum after sign extension and weighting
  logic signed [dot_width-1:0] weighted [blade_count];
  logic signed [dot_width-1:0] total;

  for (genvar i = 0; i < plane_count; i++) begin : g_a_plane
    for (genvar j = 0; j < plane_count; j++) begin : g_b_plane
      localparam int blade_idx = i*plane_count + j;
      localparam int shift     = brick_width * (i + j);

      logic signed [dot_width-1:0] ext_sum;

      assign ext_sum = {
        {(dot_width - blade_sum_width){sums[blade_idx][blade_sum_width-1]}},
        sums[blade_idx]
      };

      // bricks i and j sit at bit 2i and 2j
      assign weighted[blade_idx] = ext_sum <<< shift;
    end
  end

  // the exact sum of sixteen products always fits in 22 bits
  always_comb begin
    total = '0;
    for (int k = 0; k < blade_count; k++) begin
      total = total + weighted[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot <= '0;
    end else begin
      dot <= total;
    end
  end

endmodule

`default_nettype wire

// ==== source/bit_dot16.sv ====
// two-cycle fixed latency, one operand set per cycle, no handshake; dot reads 0 until data arrives
`default_nettype none

module bit_dot16 (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire dot_pkg::lane_ops_t       ops,
  input  wire dot_pkg::dot_mode_e       mode,
  output logic [dot_pkg::dot_width-1:0] dot
);

  import dot_pkg::*;

  brick_planes_t planes;
  blade_sums_t   sums;

  // mode is consumed in the same cycle as its operands
  brick_decode u_decode (
    .ops    (ops),
    .mode   (mode),
    .planes (planes)
  );

  // first register stage
  blade_array u_blades (
    .clk    (clk),
    .rst_n  (rst_n),
    .planes (planes),
    .sums   (sums)
  );

  // second register stage
  shift_add u_result (
    .clk   (clk),
    .rst_n (rst_n),
    .sums  (sums),
    .dot   (dot)
  );

endmodule

`default_nettype wire

// ==== verif/dot_model.svh ====
// needs dot_pkg imported by the including module; results wrap modulo 2^22 like the output port
`ifndef DOT_MODEL_SVH
`define DOT_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1 in right-shifting form
localparam logic [31:0] lfsr_taps = 32'h8020_0003;

// one step of the Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ lfsr_taps;
  end
  return state >> 1;
endfunction

// mode_su and mode_ss treat a as signed
function automatic logic a_is_signed(input dot_mode_e set_mode);
  return (set_mode == mode_su) || (set_mode == mode_ss);
endfunction

// mode_us and mode_ss treat b as signed
function automatic logic b_is_signed(input dot_mode_e set_mode);
  return (set_mode == mode_us) || (set_mode == mode_ss);
endfunction

// operand value as the mode reads it
function automatic int operand_value(
  input logic [operand_width-1:0] raw,
  input logic                     is_signed
);
  int value;
  value = int'(raw);
  if (is_signed && raw[operand_width-1]) begin
    value = value - (1 << operand_width);
  end
  return value;
endfunction

// exact sum of sixteen products cut to the output width
function automatic logic [dot_width-1:0] dot_reference(
  input lane_ops_t set_ops,
  input dot_mode_e set_mode
);
  int total;
  total = 0;
  for (int l = 0; l < lane_count; l++) begin
    total += operand_value(set_ops.a[l], a_is_signed(set_mode)) *
             operand_value(set_ops.b[l], b_is_signed(set_mode));
  end
  return total[dot_width-1:0];
endfunction

`endif

// ==== verif/bit_dot16_tb.sv ====
// results are expected exactly two edges after their inputs; one new operand set every cycle
`default_nettype none

module bit_dot16_tb;

  import dot_pkg::*;

  localparam int          clk_period   = 40;
  localparam int          reset_cycles = 10;
  localparam int          drive_delay  = 2;
  localparam int          random_sets  = 240;
  localparam int          wait_limit   = 50;
  localparam logic [31:0] lfsr_seed    = 32'h9c45_d520;

  logic                 clk;
  logic                 rst_n;
  lane_ops_t            ops;
  dot_mode_e            mode;
  logic [dot_width-1:0] dot;

  logic [31:0]          lfsr_state;
  int                   errors;
  int                   checks;
  logic                 timed_out;

  // expected results in flight with the oldest first
  logic [dot_width-1:0] expect_q [$];
  string                name_q [$];

  `include "dot_model.svh"

  bit_dot16 u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .ops   (ops),
    .mode  (mode),
    .dot   (dot)
  );

  always #(clk_period/2) clk = ~clk;

  // release a small delay after the last reset edge
  initial begin : reset_release
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
  end

  // collects the given number of LFSR output bits with the lsb last
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int n = 0; n < count; n++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic lane_ops_t random_ops();
    lane_ops_t   set_ops;
    logic [31:0] bits;
    for (int l = 0; l < lane_count; l++) begin
      bits = take_bits(operand_width);
      set_ops.a[l] = bits[operand_width-1:0];
      bits = take_bits(operand_width);
      set_ops.b[l] = bits[operand_width-1:0];
    end
    return set_ops;
  endfunction

  function automatic lane_ops_t fill_ops(
    input logic [operand_width-1:0] a_val,
    input logic [operand_width-1:0] b_val
  );
    lane_ops_t set_ops;
    for (int l = 0; l < lane_count; l++) begin
      set_ops.a[l] = a_val;
      set_ops.b[l] = b_val;
    end
    return set_ops;
  endfunction

  task automatic compare_value(
    input string                test_name,
    input logic [dot_width-1:0] expected,
    input logic [dot_width-1:0] actual
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %0d (0x%06h), actual %0d (0x%06h)",
               test_name, $signed(expected), expected, $signed(actual), actual);
    end
  endtask

  // dot now shows the set driven two cycles ago
  task automatic retire_oldest();
    logic [dot_width-1:0] expected;
    string                test_name;
    if (expect_q.size() < 2) begin
      // nothing has reached the output since reset
      compare_value("pipeline_fill", '0, dot);
    end else begin
      expected  = expect_q.pop_front();
      test_name = name_q.pop_front();
      compare_value(test_name, expected, dot);
    end
  endtask

  task automatic apply_set(
    input lane_ops_t            set_ops,
    input dot_mode_e            set_mode,
    input string                test_name,
    input logic [dot_width-1:0] expected
  );
    @(posedge clk);
    #drive_delay;
    retire_oldest();
    ops  = set_ops;
    mode = set_mode;
    expect_q.push_back(expected);
    name_q.push_back(test_name);
  endtask

  function automatic int named_pending();
    int count;
    count = 0;
    foreach (name_q[k]) begin
      if (name_q[k] != "drain") begin
        count++;
      end
    end
    return count;
  endfunction

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < reset_cycles + wait_limit) begin
      @(negedge clk);
      if (rst_n !== 1'b1) begin
        compare_value("reset", '0, dot);
      end
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was not released within %0d cycles", cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while (named_pending() > 0 && cycles < wait_limit) begin
      apply_set('0, mode_uu, "drain", '0);
      cycles++;
    end
    if (named_pending() > 0) begin
      $display("timeout: %0d results still pending after %0d drain cycles",
               named_pending(), cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic drive_random_sets();
    lane_ops_t   set_ops;
    dot_mode_e   set_mode;
    logic [31:0] bits;
    for (int n = 0; n < random_sets; n++) begin
      set_ops  = random_ops();
      bits     = take_bits(2);
      set_mode = dot_mode_e'(bits[1:0]);
      apply_set(set_ops, set_mode, "random", dot_reference(set_ops, set_mode));
    end
  endtask

  // values worked out by hand from the operand rule
  task automatic check_extremes();
    apply_set(fill_ops(8'hff, 8'hff), mode_uu, "max_uu", 22'd1040400);
    apply_set(fill_ops(8'h80, 8'h80), mode_ss, "min_ss", 22'd262144);
    apply_set(fill_ops(8'h80, 8'hff), mode_su, "mixed_su", 22'(-522240));
  endtask

  // same data under four modes in a row
  task automatic sweep_modes();
    lane_ops_t set_ops;
    dot_mode_e set_mode;
    for (int p = 0; p < 2; p++) begin
      set_ops = (p == 0) ? random_ops() : fill_ops(8'h80, 8'hff);
      for (int m = 0; m < 4; m++) begin
        set_mode = dot_mode_e'(m);
        apply_set(set_ops, set_mode, $sformatf("mode_sweep_%0d_%0d", p, m),
                  dot_reference(set_ops, set_mode));
      end
    end
  endtask

  // one nonzero brick per operand, so each set lights a single blade
  task automatic walk_lanes();
    lane_ops_t                set_ops;
    dot_mode_e                set_mode;
    logic [31:0]              bits;
    logic [brick_width-1:0]   a_brick;
    logic [brick_width-1:0]   b_brick;
    for (int l = 0; l < lane_count; l++) begin
      for (int pa = 0; pa < plane_count; pa++) begin
        for (int pb = 0; pb < plane_count; pb++) begin
          bits     = take_bits(6);
          a_brick  = (bits[1:0] == 2'b00) ? 2'b11 : bits[1:0];
          b_brick  = (bits[3:2] == 2'b00) ? 2'b11 : bits[3:2];
          set_mode = dot_mode_e'(bits[5:4]);
          set_ops  = '0;
          set_ops.a[l][pa*brick_width +: brick_width] = a_brick;
          set_ops.b[l][pb*brick_width +: brick_width] = b_brick;
          apply_set(set_ops, set_mode, $sformatf("lane_%0d_blade_%0d", l, pa*plane_count + pb),
                    dot_reference(set_ops, set_mode));
        end
      end
    end
  endtask

  initial begin : main_flow
    clk        = 1'b0;
    rst_n      = 1'b0;
    ops        = '0;
    mode       = mode_uu;
    lfsr_state = lfsr_seed;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;

    wait_reset_release();
    if (!timed_out) begin
      apply_set('0, mode_uu, "post_reset_zero", '0);
      apply_set('0, mode_uu, "post_reset_zero", '0);
      drive_random_sets();
      check_extremes();
      sweep_modes();
      walk_lanes();
      drain_pipeline();
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bit_dot16.f ====
+incdir+verif
source/dot_pkg.sv
source/brick_decode.sv
source/brick_blade.sv
source/blade_array.sv
source/shift_add.sv
source/bit_dot16.sv
verif/bit_dot16_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bit_dot16 testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f bit_dot16.f \
  --top-module bit_dot16_tb \
  -o bit_dot16_sim \
  && ./obj_dir/bit_dot16_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log

grep -q '^>>> PASS$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
